// ==== compile.f ====
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_agen.sv
verilog/ex_stage_ctrl.sv
verilog/ex_top.sv
dv/ex_asserts.sv
dv/ex_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - verilog/ex_pkg.sv
  - verilog/ex_alu.sv
  - verilog/ex_agen.sv
  - verilog/ex_stage_ctrl.sv
  - verilog/ex_top.sv
  - target: test
    files:
      - dv/ex_asserts.sv
      - dv/ex_tb.sv

// ==== dv/ex_tb.sv ====
module ex_tb
    import ex_pkg::*;
();

    localparam int STEP_BITS = 2;    // 16 cycle multiply
    localparam int TMO       = 200;  // cycles per wait

    logic             clk;
    logic             resetn;
    logic             flush;
    logic             in_valid;
    logic             in_rf_we;
    logic [XLEN-1:0]  in_pc, in_src1, in_src2, in_imm, in_rkd;
    alu_op_e          in_alu_op;
    mem_op_e          in_mem_op;
    logic [RF_AW-1:0] in_rf_waddr;
    logic             allowin, mem_allowin, out_valid, out_rf_we, out_ale;
    logic [XLEN-1:0]  out_pc, out_result;
    logic [RF_AW-1:0] out_rf_waddr;
    mem_op_e          out_mem_op;
    logic             data_sram_req, data_sram_wr, data_sram_addr_ok;
    logic [1:0]       data_sram_size;
    logic [3:0]       data_sram_wstrb;
    logic [XLEN-1:0]  data_sram_addr, data_sram_wdata;
    integer           seed = 32'h097f_4910;
    logic [1:0]       ok_delay;
    logic             bp_on;
    logic             hold_mem;
    string            test_name;
    int               tests_run, tests_bad, errs_before;
    mem_op_e          ale_ops[5] = '{MEM_LD_H, MEM_LD_HU, MEM_LD_W, MEM_ST_H, MEM_ST_W};

    ex_top #(.MUL_STEP_BITS(STEP_BITS)) dut_i (.*);

    bind ex_top ex_asserts asserts_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // addr_ok answers a request after 0 to 3 cycles
    always @(posedge clk) begin
        if (!resetn || !data_sram_req || data_sram_addr_ok) begin
            data_sram_addr_ok <= 1'b0;
            ok_delay          <= 2'($random(seed));
        end else if (ok_delay == 2'd0) begin
            data_sram_addr_ok <= 1'b1;
        end else begin
            ok_delay <= ok_delay - 2'd1;
        end
        mem_allowin <= hold_mem ? 1'b0 : bp_on ? 1'($random(seed)) : 1'b1;
    end

    function automatic logic [XLEN-1:0] rnd();
        return $random(seed);
    endfunction

    task automatic stop_stalled(input string what);
        $display("test %s stalled: no %s within %0d cycles", test_name, what, TMO);
        $display("tests failed");
        $finish;
    endtask

    // present one instruction and hold it until the stage takes it
    task automatic issue(input alu_op_e op, input mem_op_e mop,
                         input logic [XLEN-1:0] s1, s2, imm, rkd);
        int n;
        n = 0;
        @(posedge clk);
        in_valid    <= 1'b1;
        in_pc       <= in_pc + 32'd4;
        in_alu_op   <= op;
        in_mem_op   <= mop;
        in_src1     <= s1;
        in_src2     <= s2;
        in_imm      <= imm;
        in_rkd      <= rkd;
        in_rf_we    <= 1'b1;
        in_rf_waddr <= in_rf_waddr + 5'd1;
        @(negedge clk);
        while (!allowin) begin
            n++;
            if (n > TMO) stop_stalled("allowin");
            @(negedge clk);
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_leave();
        int n;
        n = 0;
        @(negedge clk);
        while (!(out_valid && mem_allowin)) begin
            n++;
            if (n > TMO) stop_stalled("out_valid");
            @(negedge clk);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        errs_before = dut_i.asserts_i.err_cnt;
    endtask

    task automatic end_test();
        int errs;
        repeat (2) @(negedge clk);  // let the last checks fire
        errs = dut_i.asserts_i.err_cnt - errs_before;
        tests_run++;
        if (errs != 0) tests_bad++;
        $display("test %-8s %s (%0d failures)", test_name, errs == 0 ? "ok" : "FAILED", errs);
    endtask

    initial begin
        mem_op_e    mop;
        logic [1:0] off;
        resetn            = 1'b0;
        flush             = 1'b0;
        in_valid          = 1'b0;
        in_pc             = 32'h1c00_0000;
        in_alu_op         = ALU_ADD;
        in_mem_op         = MEM_NONE;
        in_src1           = '0;
        in_src2           = '0;
        in_imm            = '0;
        in_rkd            = '0;
        in_rf_we          = 1'b0;
        in_rf_waddr       = '0;
        mem_allowin       = 1'b1;
        data_sram_addr_ok = 1'b0;
        bp_on             = 1'b0;
        hold_mem          = 1'b0;
        tests_run         = 0;
        tests_bad         = 0;

        start_test("reset");
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        end_test();

        start_test("alu");
        for (int i = 0; i < 48; i++) begin
            issue(alu_op_e'(i % 12), MEM_NONE, rnd(), rnd(), '0, '0);
            wait_leave();
        end
        end_test();

        start_test("mul");
        repeat (8) begin
            issue(ALU_MUL, MEM_NONE, rnd(), rnd(), '0, '0);
            wait_leave();
        end
        end_test();

        start_test("mem");
        for (int i = 0; i < 32; i++) begin
            mop = mem_op_e'(1 + i % 8);
            off = 2'(rnd());
            if (mop inside {MEM_LD_H, MEM_LD_HU, MEM_ST_H}) off[0] = 1'b0;
            if (mop inside {MEM_LD_W, MEM_ST_W}) off = 2'b00;
            issue(ALU_ADD, mop, rnd() & ~32'h3, rnd(), (rnd() & ~32'h3) | XLEN'(off), rnd());
            wait_leave();
        end
        end_test();

        start_test("ale");
        for (int i = 0; i < 20; i++) begin
            mop = ale_ops[i % 5];
            off = 2'(rnd()) | 2'b01;
            if (mop inside {MEM_LD_W, MEM_ST_W} && i % 3 == 0) off = 2'b10;
            issue(ALU_ADD, mop, rnd() & ~32'h3, rnd(), (rnd() & ~32'h3) | XLEN'(off), rnd());
            wait_leave();
        end
        end_test();

        start_test("bp_flush");
        bp_on <= 1'b1;
        for (int i = 0; i < 26; i++) begin
            mop = (i % 4 == 3) ? MEM_ST_W : MEM_NONE;  // every fourth one stores
            issue(alu_op_e'(i % 13), mop, rnd() & ~32'h3, rnd(), '0, rnd());
            wait_leave();
        end
        bp_on    <= 1'b0;
        hold_mem <= 1'b1;  // park the next result in the stage
        issue(ALU_ADD, MEM_NONE, rnd(), rnd(), '0, '0);
        flush <= 1'b1;  // the parked result must go at once
        @(posedge clk);
        flush    <= 1'b0;
        hold_mem <= 1'b0;
        issue(ALU_MUL, MEM_NONE, rnd(), rnd(), '0, '0);
        flush <= 1'b1;  // drop the multiply in flight
        @(posedge clk);
        flush <= 1'b0;
        issue(ALU_ADD, MEM_NONE, rnd(), rnd(), '0, '0);
        wait_leave();
        end_test();

        $display("%0d tests run, %0d failed, %0d assertion failures",
                 tests_run, tests_bad, dut_i.asserts_i.err_cnt);
        if (tests_bad == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== dv/ex_asserts.sv ====
module ex_asserts
    import ex_pkg::*;
(
    input logic             clk,
    input logic             resetn,
    input logic             flush,
    input logic             in_valid,
    input logic [XLEN-1:0]  in_pc,
    input alu_op_e          in_alu_op,
    input mem_op_e          in_mem_op,
    input logic [XLEN-1:0]  in_src1, in_src2, in_imm, in_rkd,
    input logic             in_rf_we,
    input logic [RF_AW-1:0] in_rf_waddr,
    input logic             allowin,
    input logic             mem_allowin,
    input logic             out_valid,
    input logic [XLEN-1:0]  out_pc, out_result,
    input logic             out_rf_we,
    input logic [RF_AW-1:0] out_rf_waddr,
    input mem_op_e          out_mem_op,
    input logic             out_ale,
    input logic             data_sram_req, data_sram_wr, data_sram_addr_ok,
    input logic [1:0]       data_sram_size,
    input logic [3:0]       data_sram_wstrb,
    input logic [XLEN-1:0]  data_sram_addr, data_sram_wdata
);

    int unsigned      err_cnt = 0;  // read by the testbench per test
    alu_op_e          op_q;
    mem_op_e          mop_q;
    logic [XLEN-1:0]  pc_q, s1_q, s2_q, imm_q, rkd_q;
    logic             we_q;
    logic [RF_AW-1:0] waddr_q;
    logic [XLEN-1:0]  exp_res, exp_addr, exp_wdata;
    logic [3:0]       exp_wstrb;
    logic [1:0]       exp_size;
    logic             exp_half, exp_word, exp_store, exp_ale;

    // one-entry model of the instruction in the stage
    always_ff @(posedge clk) begin
        if (in_valid && allowin && !flush) begin
            pc_q    <= in_pc;
            op_q    <= in_alu_op;
            mop_q   <= in_mem_op;
            s1_q    <= in_src1;
            s2_q    <= in_src2;
            imm_q   <= in_imm;
            rkd_q   <= in_rkd;
            we_q    <= in_rf_we;
            waddr_q <= in_rf_waddr;
        end
    end

    always_comb begin
        case (op_q)
            ALU_ADD:  exp_res = s1_q + s2_q;
            ALU_SUB:  exp_res = s1_q - s2_q;
            ALU_SLT:  exp_res = XLEN'($signed(s1_q) < $signed(s2_q));
            ALU_SLTU: exp_res = XLEN'(s1_q < s2_q);
            ALU_AND:  exp_res = s1_q & s2_q;
            ALU_OR:   exp_res = s1_q | s2_q;
            ALU_XOR:  exp_res = s1_q ^ s2_q;
            ALU_NOR:  exp_res = ~(s1_q | s2_q);
            ALU_SLL:  exp_res = s1_q << s2_q[4:0];
            ALU_SRL:  exp_res = s1_q >> s2_q[4:0];
            ALU_SRA:  exp_res = $signed(s1_q) >>> s2_q[4:0];
            ALU_LUI:  exp_res = s2_q << 12;
            default:  exp_res = s1_q * s2_q;  // low word of the product
        endcase
    end

    assign exp_addr  = s1_q + imm_q;
    assign exp_half  = mop_q inside {MEM_LD_H, MEM_LD_HU, MEM_ST_H};
    assign exp_word  = mop_q inside {MEM_LD_W, MEM_ST_W};
    assign exp_store = mop_q inside {MEM_ST_B, MEM_ST_H, MEM_ST_W};
    assign exp_ale   = (exp_half && exp_addr[0]) || (exp_word && exp_addr[1:0] != 2'b00);
    assign exp_size  = exp_word ? 2'd2 : exp_half ? 2'd1 : 2'd0;

    always_comb begin
        exp_wstrb = 4'b0000;
        exp_wdata = rkd_q;
        case (mop_q)
            MEM_ST_B: begin
                exp_wstrb = 4'b0001 << exp_addr[1:0];
                exp_wdata = {4{rkd_q[7:0]}};
            end
            MEM_ST_H: begin
                exp_wstrb = exp_addr[1] ? 4'b1100 : 4'b0011;
                exp_wdata = {2{rkd_q[15:0]}};
            end
            MEM_ST_W: exp_wstrb = 4'b1111;
            default: ;
        endcase
    end

    result_chk: assert property (@(posedge clk) disable iff (!resetn)
        out_valid && mop_q == MEM_NONE |-> out_result == exp_res)
    else begin
        $error("Mismatch at %0t: op %0d result %h, expected %h", $time,
               $sampled(op_q), $sampled(out_result), $sampled(exp_res));
        err_cnt++;
    end

    fields_chk: assert property (@(posedge clk) disable iff (!resetn)
        out_valid |-> out_pc == pc_q && out_rf_waddr == waddr_q && out_mem_op == mop_q &&
        out_rf_we == (we_q && !exp_ale) && (mop_q == MEM_NONE || out_result == exp_addr))
    else begin
        $error("Mismatch at %0t: pc %h waddr %0d mem_op %0d, expected %h %0d %0d",
               $time, $sampled(out_pc), $sampled(out_rf_waddr), $sampled(out_mem_op),
               $sampled(pc_q), $sampled(waddr_q), $sampled(mop_q));
        err_cnt++;
    end

    latency_chk: assert property (@(posedge clk) disable iff (!resetn)
        in_valid && allowin && !flush && in_mem_op == MEM_NONE && in_alu_op != ALU_MUL
        |=> out_valid)
    else begin
        $error("at %0t a single-cycle op did not reach out_valid one cycle later", $time);
        err_cnt++;
    end

    request_chk: assert property (@(posedge clk) disable iff (!resetn)
        data_sram_req && data_sram_addr_ok |-> data_sram_addr == exp_addr &&
        out_result == exp_addr && data_sram_wstrb == exp_wstrb &&
        data_sram_size == exp_size &&
        data_sram_wr == exp_store && (!exp_store || data_sram_wdata == exp_wdata))
    else begin
        $error("Mismatch at %0t: request addr %h size %0d wstrb %b wdata %h, expected %h %0d %b %h",
               $time, $sampled(data_sram_addr), $sampled(data_sram_size),
               $sampled(data_sram_wstrb), $sampled(data_sram_wdata), $sampled(exp_addr),
               $sampled(exp_size), $sampled(exp_wstrb), $sampled(exp_wdata));
        err_cnt++;
    end

    ale_chk: assert property (@(posedge clk) disable iff (!resetn)
        exp_ale && (out_valid || data_sram_req) |-> !data_sram_req && out_ale && !out_rf_we)
    else begin
        $error("at %0t a misaligned access raised req or kept rf_we", $time);
        err_cnt++;
    end

    // stalled outputs hold until the memory stage takes them
    hold_chk: assert property (@(posedge clk) disable iff (!resetn)
        out_valid && !mem_allowin && !flush |-> (!allowin && !data_sram_req) ##1
        (out_valid && $stable(out_pc) && $stable(out_result) && $stable(out_rf_we) &&
         $stable(out_rf_waddr) && $stable(out_mem_op) && $stable(out_ale)))
    else begin
        $error("at %0t the stage moved or requested while mem_allowin was low", $time);
        err_cnt++;
    end

    flush_chk: assert property (@(posedge clk) disable iff (!resetn)
        flush |=> !out_valid && !data_sram_req)
    else begin
        $error("at %0t the stage was still active after a flush", $time);
        err_cnt++;
    end

    reset_chk: assert property (@(posedge clk)
        $rose(resetn) |-> !out_valid && !data_sram_req && allowin)
    else begin
        $error("at %0t the stage was not idle after reset", $time);
        err_cnt++;
    end

endmodule

// ==== verilog/ex_top.sv ====
module ex_top
    import ex_pkg::*;
#(
    parameter int MUL_STEP_BITS = 1
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             flush,
    input  logic             in_valid,
    input  logic [XLEN-1:0]  in_pc,
    input  alu_op_e          in_alu_op,
    input  logic [XLEN-1:0]  in_src1,
    input  logic [XLEN-1:0]  in_src2,
    input  logic [XLEN-1:0]  in_imm,
    input  logic [XLEN-1:0]  in_rkd,
    input  mem_op_e          in_mem_op,
    input  logic             in_rf_we,
    input  logic [RF_AW-1:0] in_rf_waddr,
    output logic             allowin,
    input  logic             mem_allowin,
    output logic             out_valid,
    output logic [XLEN-1:0]  out_pc,
    output logic [XLEN-1:0]  out_result,
    output logic             out_rf_we,
    output logic [RF_AW-1:0] out_rf_waddr,
    output mem_op_e          out_mem_op,
    output logic             out_ale,
    output logic             data_sram_req,
    output logic             data_sram_wr,
    output logic [1:0]       data_sram_size,
    output logic [3:0]       data_sram_wstrb,
    output logic [XLEN-1:0]  data_sram_addr,
    output logic [XLEN-1:0]  data_sram_wdata,
    input  logic             data_sram_addr_ok
);

    // controller to alu
    logic            alu_start;
    alu_op_e         alu_op;
    logic [XLEN-1:0] alu_src1;
    logic [XLEN-1:0] alu_src2;
    logic [XLEN-1:0] alu_result;
    logic            alu_done;

    // controller to address unit
    logic [XLEN-1:0] agen_base;
    logic [XLEN-1:0] agen_imm;
    logic [XLEN-1:0] agen_rkd;
    mem_op_e         agen_mem_op;
    logic [XLEN-1:0] addr;
    logic [1:0]      size;
    logic [3:0]      wstrb;
    logic [XLEN-1:0] wdata;
    logic            is_mem;
    logic            is_store;
    logic            ale;

    ex_stage_ctrl ctrl_i (.*);

    ex_alu #(
        .MUL_STEP_BITS(MUL_STEP_BITS)
    ) alu_i (.*);

    ex_agen agen_i (.*);  // purely combinational

endmodule

// ==== verilog/ex_stage_ctrl.sv ====
module ex_stage_ctrl
    import ex_pkg::*;
(
    input  logic             clk,
    input  logic             resetn,
    input  logic             flush,
    input  logic             in_valid,
    input  logic [XLEN-1:0]  in_pc,
    input  alu_op_e          in_alu_op,
    input  logic [XLEN-1:0]  in_src1,
    input  logic [XLEN-1:0]  in_src2,
    input  logic [XLEN-1:0]  in_imm,
    input  logic [XLEN-1:0]  in_rkd,
    input  mem_op_e          in_mem_op,
    input  logic             in_rf_we,
    input  logic [RF_AW-1:0] in_rf_waddr,
    output logic             allowin,
    output logic             alu_start,
    output alu_op_e          alu_op,
    output logic [XLEN-1:0]  alu_src1,
    output logic [XLEN-1:0]  alu_src2,
    input  logic [XLEN-1:0]  alu_result,
    input  logic             alu_done,
    output logic [XLEN-1:0]  agen_base,
    output logic [XLEN-1:0]  agen_imm,
    output logic [XLEN-1:0]  agen_rkd,
    output mem_op_e          agen_mem_op,
    input  logic [XLEN-1:0]  addr,
    input  logic [1:0]       size,
    input  logic [3:0]       wstrb,
    input  logic [XLEN-1:0]  wdata,
    input  logic             is_mem,
    input  logic             is_store,
    input  logic             ale,
    input  logic             mem_allowin,
    output logic             out_valid,
    output logic [XLEN-1:0]  out_pc,
    output logic [XLEN-1:0]  out_result,
    output logic             out_rf_we,
    output logic [RF_AW-1:0] out_rf_waddr,
    output mem_op_e          out_mem_op,
    output logic             out_ale,
    output logic             data_sram_req,
    output logic             data_sram_wr,
    output logic [1:0]       data_sram_size,
    output logic [3:0]       data_sram_wstrb,
    output logic [XLEN-1:0]  data_sram_addr,
    output logic [XLEN-1:0]  data_sram_wdata,
    input  logic             data_sram_addr_ok
);

    logic             valid_q;
    logic             start_q;
    logic [XLEN-1:0]  pc_q;
    alu_op_e          alu_op_q;
    logic [XLEN-1:0]  src1_q;
    logic [XLEN-1:0]  src2_q;
    logic [XLEN-1:0]  imm_q;
    logic [XLEN-1:0]  rkd_q;
    mem_op_e          mem_op_q;
    logic             rf_we_q;
    logic [RF_AW-1:0] rf_waddr_q;
    logic             accept;
    logic             mem_pending;  // memory op still owes its request
    logic             ready_go;

    assign mem_pending = valid_q & is_mem & ~ale;
    // wait for the alu so a request is never sent twice
    assign data_sram_req = mem_pending & alu_done & mem_allowin & ~flush;

    assign ready_go  = alu_done & (~mem_pending | (data_sram_req & data_sram_addr_ok));
    assign allowin   = ~valid_q | (ready_go & mem_allowin);
    assign out_valid = valid_q & ready_go;
    assign accept    = in_valid & allowin & ~flush;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= accept;  // alu kicks off the cycle after
            if (flush) begin
                valid_q <= 1'b0;
            end else if (allowin) begin
                valid_q <= in_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q       <= in_pc;
            alu_op_q   <= in_alu_op;
            src1_q     <= in_src1;
            src2_q     <= in_src2;
            imm_q      <= in_imm;
            rkd_q      <= in_rkd;
            mem_op_q   <= in_mem_op;
            rf_we_q    <= in_rf_we;
            rf_waddr_q <= in_rf_waddr;
        end
    end

    assign alu_start = start_q;
    assign alu_op    = alu_op_q;
    assign alu_src1  = src1_q;
    assign alu_src2  = src2_q;

    assign agen_base   = src1_q;  // rj is the base register
    assign agen_imm    = imm_q;
    assign agen_rkd    = rkd_q;
    assign agen_mem_op = mem_op_q;

    assign data_sram_wr    = is_store;
    assign data_sram_size  = size;
    assign data_sram_wstrb = wstrb;
    assign data_sram_addr  = addr;
    assign data_sram_wdata = wdata;

    assign out_pc       = pc_q;
    assign out_result   = is_mem ? addr : alu_result;
    assign out_rf_we    = rf_we_q & ~ale;  // faulting load writes nothing
    assign out_rf_waddr = rf_waddr_q;
    assign out_mem_op   = mem_op_q;
    assign out_ale      = ale;

endmodule

// ==== verilog/ex_agen.sv ====
module ex_agen
    import ex_pkg::*;
(
    input  logic [XLEN-1:0] agen_base,
    input  logic [XLEN-1:0] agen_imm,
    input  logic [XLEN-1:0] agen_rkd,
    input  mem_op_e         agen_mem_op,
    output logic [XLEN-1:0] addr,
    output logic [1:0]      size,
    output logic [3:0]      wstrb,
    output logic [XLEN-1:0] wdata,
    output logic            is_mem,
    output logic            is_store,
    output logic            ale
);

    logic is_byte;
    logic is_half;
    logic is_word;

    assign addr = agen_base + agen_imm;

    always_comb begin
        is_byte  = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        is_store = 1'b0;
        case (agen_mem_op)
            MEM_LD_B, MEM_LD_BU: is_byte = 1'b1;
            MEM_LD_H, MEM_LD_HU: is_half = 1'b1;
            MEM_LD_W:            is_word = 1'b1;
            MEM_ST_B: begin
                is_byte  = 1'b1;
                is_store = 1'b1;
            end
            MEM_ST_H: begin
                is_half  = 1'b1;
                is_store = 1'b1;
            end
            MEM_ST_W: begin
                is_word  = 1'b1;
                is_store = 1'b1;
            end
            default: ;  // MEM_NONE
        endcase
    end

    assign is_mem = is_byte | is_half | is_word;

    assign size = is_word ? 2'd2 :
                  is_half ? 2'd1 : 2'd0;

    always_comb begin
        wstrb = 4'b0000;  // loads write nothing
        if (is_store) begin
            if (is_byte) begin
                wstrb = 4'b0001 << addr[1:0];
            end else if (is_half) begin
                wstrb = addr[1] ? 4'b1100 : 4'b0011;
            end else begin
                wstrb = 4'b1111;
            end
        end
    end

    // replicate so every lane carries the store value
    assign wdata = is_byte ? {4{agen_rkd[7:0]}} :
                   is_half ? {2{agen_rkd[15:0]}} : agen_rkd;

    assign ale = (is_half & addr[0]) | (is_word & (addr[1] | addr[0]));

endmodule

// ==== verilog/ex_alu.sv ====
module ex_alu
    import ex_pkg::*;
#(
    parameter int MUL_STEP_BITS = 1
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            alu_start,
    input  alu_op_e         alu_op,
    input  logic [XLEN-1:0] alu_src1,
    input  logic [XLEN-1:0] alu_src2,
    output logic [XLEN-1:0] alu_result,
    output logic            alu_done
);

    localparam int STEPS   = XLEN / MUL_STEP_BITS;  // multiply iterations
    localparam int CNT_W   = $clog2(STEPS) + 1;
    localparam int SHAMT_W = $clog2(XLEN);

    typedef enum logic {
        MUL_IDLE,
        MUL_BUSY
    } mul_state_e;

    mul_state_e         state_q;
    logic [CNT_W-1:0]   step_cnt_q;  // steps left after this one
    logic               done_q;
    logic [XLEN-1:0]    result_q;    // also the product accumulator
    logic [XLEN-1:0]    mcand_q;
    logic [XLEN-1:0]    mplier_q;
    logic [XLEN-1:0]    single_res;
    logic [XLEN-1:0]    partial;
    logic [SHAMT_W-1:0] shamt;

    assign shamt = alu_src2[SHAMT_W-1:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  single_res = alu_src1 + alu_src2;
            ALU_SUB:  single_res = alu_src1 - alu_src2;
            ALU_SLT:  single_res = {{(XLEN-1){1'b0}}, $signed(alu_src1) < $signed(alu_src2)};
            ALU_SLTU: single_res = {{(XLEN-1){1'b0}}, alu_src1 < alu_src2};
            ALU_AND:  single_res = alu_src1 & alu_src2;
            ALU_OR:   single_res = alu_src1 | alu_src2;
            ALU_XOR:  single_res = alu_src1 ^ alu_src2;
            ALU_NOR:  single_res = ~(alu_src1 | alu_src2);
            ALU_SLL:  single_res = alu_src1 << shamt;
            ALU_SRL:  single_res = alu_src1 >> shamt;
            ALU_SRA:  single_res = $signed(alu_src1) >>> shamt;
            ALU_LUI:  single_res = {alu_src2[19:0], 12'h000};
            default:  single_res = '0;  // mul goes through the iterator
        endcase
    end

    // one shift-add step over MUL_STEP_BITS multiplier bits
    always_comb begin
        partial = '0;
        for (int i = 0; i < MUL_STEP_BITS; i++) begin
            if (mplier_q[i]) begin
                partial = partial + (mcand_q << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q    <= MUL_IDLE;
            step_cnt_q <= '0;
            done_q     <= 1'b0;
        end else if (alu_start) begin  // restarts even a busy multiply
            if (alu_op == ALU_MUL) begin
                state_q    <= MUL_BUSY;
                step_cnt_q <= CNT_W'(STEPS - 1);
                done_q     <= 1'b0;
            end else begin
                state_q <= MUL_IDLE;
                done_q  <= 1'b1;
            end
        end else if (state_q == MUL_BUSY) begin
            step_cnt_q <= step_cnt_q - 1'b1;
            if (step_cnt_q == '0) begin  // last step
                state_q <= MUL_IDLE;
                done_q  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            mcand_q  <= alu_src1;
            mplier_q <= alu_src2;
            result_q <= (alu_op == ALU_MUL) ? '0 : single_res;
        end else if (state_q == MUL_BUSY) begin
            mcand_q  <= mcand_q << MUL_STEP_BITS;
            mplier_q <= mplier_q >> MUL_STEP_BITS;
            result_q <= result_q + partial;  // low word of the product
        end
    end

    // single-cycle ops answer in the start cycle itself
    assign alu_result = alu_start ? single_res : result_q;
    assign alu_done   = alu_start ? (alu_op != ALU_MUL) : done_q;

endmodule

// ==== verilog/ex_pkg.sv ====
package ex_pkg;

    localparam int XLEN  = 32;  // data and address width
    localparam int RF_AW = 5;   // register file address width

    // alu operation select, decoded upstream
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,   // signed compare
        ALU_SLTU = 4'd3,   // unsigned compare
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11,  // upper 20 bits of src2
        ALU_MUL  = 4'd12   // multi-cycle, low word only
    } alu_op_e;

    // memory access kind carried down the pipe
    typedef enum logic [3:0] {
        MEM_NONE  = 4'd0,
        MEM_LD_B  = 4'd1,
        MEM_LD_H  = 4'd2,
        MEM_LD_W  = 4'd3,
        MEM_LD_BU = 4'd4,
        MEM_LD_HU = 4'd5,
        MEM_ST_B  = 4'd6,
        MEM_ST_H  = 4'd7,
        MEM_ST_W  = 4'd8
    } mem_op_e;

endpackage
